//--- logic/arith_pkg.sv
// Shared data width, operation encoding and request/result payload structs

package arith_pkg;

  // Operand width for the whole unit
  localparam int DATA_WIDTH = 16;

  // One operand or one result word
  typedef logic [DATA_WIDTH-1:0] data_t;

  // Operation select
  typedef enum logic {
    OP_MUL = 1'b0,
    OP_DIV = 1'b1
  } arith_op_t;

  // Request payload, 34 bits at 16-bit data
  typedef struct packed {
    arith_op_t op;
    // Treat both operands as two's complement
    logic      is_signed;
    // Multiplicand or dividend
    data_t     left;
    // Multiplier or divisor
    data_t     right;
  } arith_req_t;

  // Result payload, 32 bits at 16-bit data
  typedef struct packed {
    // Upper product half, or remainder
    data_t hi;
    // Lower product half, or quotient
    data_t lo;
  } arith_res_t;

endpackage

//--- logic/mult_pipe.sv
// Two-stage pipelined multiplier, signed or unsigned, full double-width product

`timescale 1ns/1ps

module mult_pipe #(
  parameter int WIDTH = 16
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               in_valid,
  input  logic               is_signed,
  input  logic [WIDTH-1:0]   left,
  input  logic [WIDTH-1:0]   right,
  output logic [2*WIDTH-1:0] product,
  output logic               out_valid
);

  // Operands widened to the product width in stage one
  logic [2*WIDTH-1:0] left_ext;
  logic [2*WIDTH-1:0] right_ext;

  // Bit 0 marks stage one, bit 1 marks stage two
  logic [1:0] valid_sr;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_sr <= '0;
    end else begin
      valid_sr <= {valid_sr[0], in_valid};
    end
  end

  // Stage one: register operands, extended by signedness
  always_ff @(posedge clk) begin
    if (in_valid) begin
      if (is_signed) begin
        left_ext  <= {{WIDTH{left[WIDTH-1]}}, left};
        right_ext <= {{WIDTH{right[WIDTH-1]}}, right};
      end else begin
        left_ext  <= {{WIDTH{1'b0}}, left};
        right_ext <= {{WIDTH{1'b0}}, right};
      end
    end
  end

  // Stage two: full product
  // Truncation to 2*WIDTH keeps the two's complement result exact
  always_ff @(posedge clk) begin
    if (valid_sr[0]) begin
      product <= left_ext * right_ext;
    end
  end

  assign out_valid = valid_sr[1];

endmodule

//--- logic/div_core.sv
// Unsigned iterative divider with one-hot quotient mask and early finish on zero dividend

`timescale 1ns/1ps

module div_core #(
  parameter int WIDTH = 16
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             start,
  input  logic [WIDTH-1:0] dividend,
  input  logic [WIDTH-1:0] divisor,
  output logic [WIDTH-1:0] quotient,
  output logic [WIDTH-1:0] remainder,
  output logic             done
);

  // Divisor window, starts aligned to the dividend MSB
  logic [2*WIDTH-2:0] div_win;
  // Partial remainder, ends as the final remainder
  logic [WIDTH-1:0]   rem_q;
  logic [WIDTH-1:0]   quot_q;
  logic [WIDTH-1:0]   quot_msk;
  logic [WIDTH-1:0]   msk_next;
  logic               running;
  logic               fits;
  logic               finished;
  logic               zero_start;

  assign fits       = running && (div_win <= {{(WIDTH-1){1'b0}}, rem_q});
  assign msk_next   = quot_msk >> 1;
  // Last compare step, the mask empties on this edge
  assign finished   = running && (msk_next == '0);
  assign zero_start = start && (dividend == '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      running <= 1'b0;
    end else if (start && !zero_start) begin
      running <= 1'b1;
    end else if (finished) begin
      running <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      done <= 1'b0;
    end else begin
      done <= finished || zero_start;
    end
  end

  // Restoring divide, one quotient bit per cycle from the MSB down
  always_ff @(posedge clk) begin
    if (start) begin
      rem_q    <= dividend;
      quot_q   <= '0;
      quot_msk <= {1'b1, {(WIDTH-1){1'b0}}};
      div_win  <= {divisor, {(WIDTH-1){1'b0}}};
    end else if (running) begin
      if (fits) begin
        // Window fits, so its upper bits are already zero
        rem_q  <= rem_q - div_win[WIDTH-1:0];
        quot_q <= quot_q | quot_msk;
      end
      quot_msk <= msk_next;
      div_win  <= div_win >> 1;
    end
  end

  // Zero dividend loads zero into both at start
  assign quotient  = quot_q;
  assign remainder = rem_q;

  // The caller must wait for done before the next start
  a_no_start_while_running: assert property (
    @(posedge clk) disable iff (reset) running |-> !start
  );

  a_done_pulse: assert property (
    @(posedge clk) disable iff (reset) done |=> !done
  );

endmodule

//--- logic/divider.sv
// Signed/unsigned divider: magnitude forming and sign correction around div_core

`timescale 1ns/1ps

module divider
  import arith_pkg::*;
#(
  parameter int WIDTH = DATA_WIDTH
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             start,
  input  logic             is_signed,
  input  logic [WIDTH-1:0] left,
  input  logic [WIDTH-1:0] right,
  output logic [WIDTH-1:0] quotient,
  output logic [WIDTH-1:0] remainder,
  output logic             done
);

  logic [WIDTH-1:0] left_mag;
  logic [WIDTH-1:0] right_mag;
  logic [WIDTH-1:0] right_mag_q;
  logic [WIDTH-1:0] core_quot;
  logic [WIDTH-1:0] core_rem;
  logic [WIDTH-1:0] rem_fix;
  logic             left_neg;
  logic             right_neg;
  logic             left_sign_q;
  logic             right_sign_q;
  logic             diff_signs;

  // Negative only counts for signed operations
  assign left_neg  = is_signed && left[WIDTH-1];
  assign right_neg = is_signed && right[WIDTH-1];
  assign left_mag  = left_neg ? -left : left;
  assign right_mag = right_neg ? -right : right;

  // Operands may change after start, so keep what the fixup needs
  always_ff @(posedge clk) begin
    if (reset) begin
      left_sign_q  <= 1'b0;
      right_sign_q <= 1'b0;
    end else if (start) begin
      left_sign_q  <= left_neg;
      right_sign_q <= right_neg;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      right_mag_q <= right_mag;
    end
  end

  div_core #(
    .WIDTH(WIDTH)
  ) u_div_core (
    .clk      (clk),
    .reset    (reset),
    .start    (start),
    .dividend (left_mag),
    .divisor  (right_mag),
    .quotient (core_quot),
    .remainder(core_rem),
    .done     (done)
  );

  assign diff_signs = left_sign_q ^ right_sign_q;
  assign quotient   = diff_signs ? -core_quot : core_quot;

  // Remainder follows the sign of the divisor
  assign rem_fix   = (diff_signs && (core_rem != '0)) ? right_mag_q - core_rem : core_rem;
  assign remainder = right_sign_q ? -rem_fix : rem_fix;

endmodule

//--- logic/op_sequencer.sv
// Request acceptance, dispatch to multiplier or divider, result capture and hold

`timescale 1ns/1ps

module op_sequencer
  import arith_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  arith_req_t                req,
  input  logic                      req_valid,
  output logic                      req_ready,
  output arith_res_t                res,
  output logic                      res_valid,
  input  logic                      res_ready,
  output logic                      mul_start,
  input  logic [2*DATA_WIDTH-1:0]   mul_product,
  input  logic                      mul_valid,
  output logic                      div_start,
  input  data_t                     div_quotient,
  input  data_t                     div_remainder,
  input  logic                      div_done,
  output logic                      is_signed,
  output data_t                     left,
  output data_t                     right
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUSY,
    ST_HOLD
  } state_t;

  state_t     state;
  arith_op_t  op_q;
  arith_res_t res_q;
  arith_res_t completion;
  logic       accept;
  logic       complete;

  assign req_ready = (state == ST_IDLE);
  assign res_valid = (state == ST_HOLD);
  assign accept    = req_valid && req_ready;

  // Only the unit that was started can finish
  assign complete = (op_q == OP_MUL) ? mul_valid : div_done;

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= ST_IDLE;
      mul_start <= 1'b0;
      div_start <= 1'b0;
    end else begin
      mul_start <= accept && (req.op == OP_MUL);
      div_start <= accept && (req.op == OP_DIV);
      case (state)
        ST_IDLE: if (accept) state <= ST_BUSY;
        ST_BUSY: if (complete) state <= ST_HOLD;
        ST_HOLD: if (res_ready) state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Operands stay put for the whole operation
  always_ff @(posedge clk) begin
    if (accept) begin
      op_q      <= req.op;
      is_signed <= req.is_signed;
      left      <= req.left;
      right     <= req.right;
    end
  end

  // Pack the finishing unit's outputs into hi/lo
  always_comb begin
    if (op_q == OP_MUL) begin
      completion.hi = mul_product[2*DATA_WIDTH-1:DATA_WIDTH];
      completion.lo = mul_product[DATA_WIDTH-1:0];
    end else begin
      completion.hi = div_remainder;
      completion.lo = div_quotient;
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_BUSY && complete) begin
      res_q <= completion;
    end
  end

  assign res = res_q;

  a_res_stable: assert property (
    @(posedge clk) disable iff (reset)
      res_valid && !res_ready |=> res_valid && $stable(res)
  );

  a_no_completion_idle: assert property (
    @(posedge clk) disable iff (reset)
      state == ST_IDLE |-> !(mul_valid || div_done)
  );

endmodule

//--- logic/arith_unit.sv
// Top level: valid/ready sequencer wired to the multiplier and divider

`timescale 1ns/1ps

module arith_unit
  import arith_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  arith_req_t req,
  input  logic       req_valid,
  output logic       req_ready,
  output arith_res_t res,
  output logic       res_valid,
  input  logic       res_ready
);

  localparam int WIDTH = DATA_WIDTH;

  logic               mul_start;
  logic [2*WIDTH-1:0] mul_product;
  logic               mul_valid;
  logic               div_start;
  data_t              div_quotient;
  data_t              div_remainder;
  logic               div_done;
  logic               is_signed;
  data_t              left;
  data_t              right;

  op_sequencer u_op_sequencer (
    .clk          (clk),
    .reset        (reset),
    .req          (req),
    .req_valid    (req_valid),
    .req_ready    (req_ready),
    .res          (res),
    .res_valid    (res_valid),
    .res_ready    (res_ready),
    .mul_start    (mul_start),
    .mul_product  (mul_product),
    .mul_valid    (mul_valid),
    .div_start    (div_start),
    .div_quotient (div_quotient),
    .div_remainder(div_remainder),
    .div_done     (div_done),
    .is_signed    (is_signed),
    .left         (left),
    .right        (right)
  );

  mult_pipe #(
    .WIDTH(WIDTH)
  ) u_mult_pipe (
    .clk      (clk),
    .reset    (reset),
    .in_valid (mul_start),
    .is_signed(is_signed),
    .left     (left),
    .right    (right),
    .product  (mul_product),
    .out_valid(mul_valid)
  );

  divider #(
    .WIDTH(WIDTH)
  ) u_divider (
    .clk      (clk),
    .reset    (reset),
    .start    (div_start),
    .is_signed(is_signed),
    .left     (left),
    .right    (right),
    .quotient (div_quotient),
    .remainder(div_remainder),
    .done     (div_done)
  );

endmodule

//--- include/arith_ref_model.svh
// Reference model functions for expected products, quotients and remainders

`ifndef ARITH_REF_MODEL_SVH
`define ARITH_REF_MODEL_SVH

// Full double-width product, sign- or zero-extended operands
function automatic arith_pkg::arith_res_t ref_mul(logic is_signed, arith_pkg::data_t left,
                                                  arith_pkg::data_t right);
  logic [2*arith_pkg::DATA_WIDTH-1:0] a;
  logic [2*arith_pkg::DATA_WIDTH-1:0] b;
  logic [2*arith_pkg::DATA_WIDTH-1:0] p;
  arith_pkg::arith_res_t              res;
  if (is_signed) begin
    a = {{arith_pkg::DATA_WIDTH{left[arith_pkg::DATA_WIDTH-1]}}, left};
    b = {{arith_pkg::DATA_WIDTH{right[arith_pkg::DATA_WIDTH-1]}}, right};
  end else begin
    a = {{arith_pkg::DATA_WIDTH{1'b0}}, left};
    b = {{arith_pkg::DATA_WIDTH{1'b0}}, right};
  end
  p = a * b;
  {res.hi, res.lo} = p;
  return res;
endfunction

// Truncating quotient, remainder takes the sign of the divisor
function automatic arith_pkg::arith_res_t ref_div(logic is_signed, arith_pkg::data_t left,
                                                  arith_pkg::data_t right);
  logic                  lneg;
  logic                  rneg;
  arith_pkg::data_t      lmag;
  arith_pkg::data_t      rmag;
  arith_pkg::data_t      t0;
  arith_pkg::data_t      t1;
  arith_pkg::arith_res_t res;
  lneg   = is_signed && left[arith_pkg::DATA_WIDTH-1];
  rneg   = is_signed && right[arith_pkg::DATA_WIDTH-1];
  lmag   = lneg ? -left : left;
  rmag   = rneg ? -right : right;
  res.lo = lmag / rmag;
  t0     = lmag % rmag;
  if (lneg ^ rneg) begin
    res.lo = -res.lo;
  end
  t1     = ((lneg ^ rneg) && (t0 != '0)) ? rmag - t0 : t0;
  res.hi = rneg ? -t1 : t1;
  return res;
endfunction

function automatic arith_pkg::arith_res_t ref_result(arith_pkg::arith_req_t req);
  if (req.op == arith_pkg::OP_MUL) begin
    return ref_mul(req.is_signed, req.left, req.right);
  end
  return ref_div(req.is_signed, req.left, req.right);
endfunction

`endif

//--- verification/arith_unit_tb.sv
// Testbench for arith_unit: clock, reset, random requests, result scoreboard, watchdog, report

`timescale 1ns/1ps

module arith_unit_tb
  import arith_pkg::*;
();

  localparam int    NUM_RAND        = 200;
  localparam int    NUM_DIRECTED    = 10;
  localparam int    NUM_REQ         = 4 * NUM_RAND + NUM_DIRECTED;
  localparam int    RESET_CYCLES    = 10;
  localparam int    MAX_HOLD        = 6;
  localparam int    HOLD_PAT_LEN    = 256;
  // Worst divide plus handshake and back-pressure per request
  localparam int    WATCHDOG_CYCLES = NUM_REQ * (DATA_WIDTH + 10) + RESET_CYCLES;
  localparam data_t MOST_NEG        = {1'b1, {(DATA_WIDTH-1){1'b0}}};

  logic        clk;
  logic        reset;
  arith_req_t  req;
  logic        req_valid;
  logic        req_ready;
  arith_res_t  res;
  logic        res_valid;
  logic        res_ready = 1'b0;

  arith_req_t  pending[$];
  arith_req_t  cur_req;
  arith_res_t  exp_res;
  arith_res_t  held_res;
  logic        held_valid = 1'b0;
  logic        hold_loaded = 1'b0;
  int unsigned hold_pat[HOLD_PAT_LEN];
  int unsigned hold_left = 0;
  int unsigned hold_idx = 0;
  int          sent_count = 0;
  int          result_count = 0;
  int          err_count = 0;

  `include "arith_ref_model.svh"

  arith_unit u_arith_unit (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_valid(req_valid),
    .req_ready(req_ready),
    .res      (res),
    .res_valid(res_valid),
    .res_ready(res_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired: %0d of %0d results after %0d cycles",
             result_count, NUM_REQ, WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

  function automatic data_t rand_word();
    return data_t'($urandom());
  endfunction

  // Hold the request on the bus until the edge that takes it
  task automatic send_request(arith_op_t op, logic sgn, data_t l, data_t r);
    @(negedge clk);
    req.op        = op;
    req.is_signed = sgn;
    req.left      = l;
    req.right     = r;
    req_valid     = 1'b1;
    @(posedge clk);
    while (!req_ready) @(posedge clk);
    pending.push_back(req);
    sent_count++;
    @(negedge clk);
    req_valid = 1'b0;
  endtask

  // Consumer: each new result gets a hold length from the pattern
  always @(negedge clk) begin
    if (reset || !res_valid) begin
      res_ready   = 1'b0;
      hold_loaded = 1'b0;
    end else begin
      if (!hold_loaded) begin
        hold_left   = hold_pat[hold_idx % HOLD_PAT_LEN];
        hold_idx++;
        hold_loaded = 1'b1;
      end
      if (hold_left > 0) begin
        res_ready = 1'b0;
        hold_left--;
      end else begin
        res_ready = 1'b1;
      end
    end
  end

  // Scoreboard and back-pressure checks on each rising edge
  always @(posedge clk) begin
    if (!reset) begin
      if (res_valid) begin
        assert (!req_ready) else begin
          err_count++;
          $display("FAIL req_ready: expected 0, got %h", req_ready);
        end
      end
      if (held_valid) begin
        assert (res_valid) else begin
          err_count++;
          $display("FAIL res_valid: expected 1, got %h", res_valid);
        end
        assert (res == held_res) else begin
          err_count++;
          $display("FAIL res: expected %h while held, got %h", held_res, res);
        end
      end
      held_valid = 1'b0;
      if (res_valid && res_ready) begin
        assert (pending.size() > 0) else begin
          err_count++;
          $display("A result was delivered with no request outstanding");
        end
        if (pending.size() > 0) begin
          cur_req = pending.pop_front();
          exp_res = ref_result(cur_req);
          assert (res.hi == exp_res.hi) else begin
            err_count++;
            $display("FAIL res.hi: expected %h, got %h (req %h)", exp_res.hi, res.hi, cur_req);
          end
          assert (res.lo == exp_res.lo) else begin
            err_count++;
            $display("FAIL res.lo: expected %h, got %h (req %h)", exp_res.lo, res.lo, cur_req);
          end
          result_count++;
        end
      end else if (res_valid) begin
        held_res   = res;
        held_valid = 1'b1;
      end
    end
  end

  initial begin
    int    seed_sink;
    data_t l;
    data_t r;
    seed_sink = $urandom(32'hd2dd);
    reset     = 1'b1;
    req       = '0;
    req_valid = 1'b0;
    // Roughly one result in three is held back
    for (int i = 0; i < HOLD_PAT_LEN; i++) begin
      hold_pat[i] = ($urandom_range(0, 2) == 0) ? $urandom_range(1, MAX_HOLD) : 0;
    end
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    assert (req_ready === 1'b1) else begin
      err_count++;
      $display("FAIL req_ready: expected 1, got %h", req_ready);
    end
    assert (res_valid === 1'b0) else begin
      err_count++;
      $display("FAIL res_valid: expected 0, got %h", res_valid);
    end

    for (int i = 0; i < NUM_RAND; i++) begin
      l = rand_word();
      r = rand_word();
      send_request(OP_MUL, 1'b0, l, r);
    end

    for (int i = 0; i < NUM_RAND; i++) begin
      l = rand_word();
      r = rand_word();
      if ($urandom_range(0, 7) == 0) l = MOST_NEG;
      if ($urandom_range(0, 7) == 0) r = MOST_NEG;
      send_request(OP_MUL, 1'b1, l, r);
    end
    send_request(OP_MUL, 1'b1, MOST_NEG, MOST_NEG);
    send_request(OP_MUL, 1'b1, MOST_NEG, ~MOST_NEG);
    send_request(OP_MUL, 1'b1, MOST_NEG, '1);
    send_request(OP_MUL, 1'b1, MOST_NEG, data_t'(1));

    // Small divisors now and then for wide quotients
    for (int i = 0; i < NUM_RAND; i++) begin
      l = rand_word();
      r = rand_word() >> $urandom_range(0, DATA_WIDTH - 1);
      if (r == '0) r = data_t'(1);
      send_request(OP_DIV, 1'b0, l, r);
    end
    send_request(OP_DIV, 1'b0, '0, data_t'(5));
    send_request(OP_DIV, 1'b0, '0, '1);

    // Index bits pick the four sign combinations in turn
    for (int i = 0; i < NUM_RAND; i++) begin
      l = rand_word();
      r = rand_word() >> $urandom_range(0, DATA_WIDTH - 2);
      l[DATA_WIDTH-1] = i[0];
      r[DATA_WIDTH-1] = i[1];
      if (r == '0) r = data_t'(1);
      send_request(OP_DIV, 1'b1, l, r);
    end
    send_request(OP_DIV, 1'b1, '0, data_t'(-13));
    send_request(OP_DIV, 1'b1, '0, data_t'(7));
    send_request(OP_DIV, 1'b1, MOST_NEG, '1);
    send_request(OP_DIV, 1'b1, MOST_NEG, data_t'(3));

    wait (result_count == sent_count);
    repeat (4) @(negedge clk);
    // Unit must be back in idle with no extra result on the bus
    assert (res_valid === 1'b0) else begin
      err_count++;
      $display("FAIL res_valid: expected 0, got %h", res_valid);
    end
    assert (req_ready === 1'b1) else begin
      err_count++;
      $display("FAIL req_ready: expected 1, got %h", req_ready);
    end
    $display("Sent %0d, results %0d, errors %0d", sent_count, result_count, err_count);
    if (err_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+include
logic/arith_pkg.sv
logic/mult_pipe.sv
logic/div_core.sv
logic/divider.sv
logic/op_sequencer.sv
logic/arith_unit.sv
verification/arith_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the arith_unit testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module arith_unit_tb -o sim_arith_unit
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_arith_unit > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Test completed successfully$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
